// ==== verilog/rv32i_types_pkg.sv ====
package rv32i_types_pkg;

  // Major opcodes, instruction bits [6:0]
  typedef enum logic [6:0] {
    LUI     = 7'b0110111,
    AUIPC   = 7'b0010111,
    JAL     = 7'b1101111,
    JALR    = 7'b1100111,
    BRANCH  = 7'b1100011,
    LOAD    = 7'b0000011,
    STORE   = 7'b0100011,
    IMMED   = 7'b0010011,
    REGREG  = 7'b0110011,
    MISCMEM = 7'b0001111,
    SYSTEM  = 7'b1110011
  } opcode_t;

  // funct3 of register-register ops
  typedef enum logic [2:0] {
    ADDSUB = 3'b000,
    SLL    = 3'b001,
    SLT    = 3'b010,
    SLTU   = 3'b011,
    XOR    = 3'b100,
    SR     = 3'b101,
    OR     = 3'b110,
    AND    = 3'b111
  } funct3_r_t;

  // funct3 of register-immediate ops
  typedef enum logic [2:0] {
    ADDI  = 3'b000,
    SLLI  = 3'b001,
    SLTI  = 3'b010,
    SLTIU = 3'b011,
    XORI  = 3'b100,
    SRI   = 3'b101,
    ORI   = 3'b110,
    ANDI  = 3'b111
  } funct3_i_t;

  // funct3 under the SYSTEM opcode
  typedef enum logic [2:0] {
    PRIV   = 3'b000,
    CSRRW  = 3'b001,
    CSRRS  = 3'b010,
    CSRRC  = 3'b011,
    CSRRWI = 3'b101,
    CSRRSI = 3'b110,
    CSRRCI = 3'b111
  } rv32i_system_t;

  // imm[11:0] of PRIV instructions
  typedef enum logic [11:0] {
    ECALL  = 12'h000,
    EBREAK = 12'h001
  } priv_insn_t;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    opcode_t    opcode;
  } rtype_t;

  typedef struct packed {
    logic [11:0] imm11_00;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    opcode_t     opcode;
  } itype_t;

  typedef struct packed {
    logic [19:0] imm31_12;
    logic [4:0]  rd;
    opcode_t     opcode;
  } utype_t;

  // J format keeps the scrambled immediate order of the ISA
  typedef struct packed {
    logic       imm20;
    logic [9:0] imm10_01;
    logic       imm11;
    logic [7:0] imm19_12;
    logic [4:0] rd;
    opcode_t    opcode;
  } ujtype_t;

endpackage

// ==== verilog/pipe_types_pkg.sv ====
package pipe_types_pkg;

  localparam int XLEN     = 32;
  localparam int NUM_REGS = 32;
  localparam int REG_AW   = $clog2(NUM_REGS);

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_SLTU
  } alu_op_t;

  typedef enum logic {
    A_RS1,
    A_PC
  } a_sel_t;

  typedef enum logic {
    B_RS2,
    B_IMM
  } b_sel_t;

  // Writeback source
  typedef enum logic [1:0] {
    W_ALU,
    W_IMM,
    W_PC4
  } w_sel_t;

  // Control word leaving decode
  typedef struct packed {
    logic              valid;
    logic [XLEN-1:0]   pc;
    logic [XLEN-1:0]   imm;
    logic [REG_AW-1:0] rs1;
    logic [REG_AW-1:0] rs2;
    logic [REG_AW-1:0] rd;
    alu_op_t           alu_op;
    a_sel_t            a_sel;
    b_sel_t            b_sel;
    w_sel_t            w_sel;
    logic              wen;
    logic              illegal;
    logic              ecall;
    logic              ebreak;
  } decoded_t;

  // Source numbers are consumed by the register read
  typedef struct packed {
    logic              valid;
    logic [XLEN-1:0]   pc;
    logic [XLEN-1:0]   imm;
    logic [REG_AW-1:0] rd;
    alu_op_t           alu_op;
    a_sel_t            a_sel;
    b_sel_t            b_sel;
    w_sel_t            w_sel;
    logic              wen;
    logic              illegal;
    logic              ecall;
    logic              ebreak;
    logic [XLEN-1:0]   rs1_val;
    logic [XLEN-1:0]   rs2_val;
  } operands_t;

  typedef struct packed {
    logic              wen;
    logic [REG_AW-1:0] rd;
    logic [XLEN-1:0]   data;
    logic              illegal;
    logic              ecall;
    logic              ebreak;
  } retire_t;

endpackage

// ==== verilog/control_unit.sv ====
module control_unit (
  input  logic                                  clk,
  input  logic                                  rst_i,
  input  logic                                  instr_valid_i,
  input  logic [31:0]                           instr_i,
  input  logic [pipe_types_pkg::XLEN-1:0]       pc_i,
  output pipe_types_pkg::decoded_t              dec_o
);

  rv32i_types_pkg::opcode_t opcode;
  rv32i_types_pkg::rtype_t  r_view;
  rv32i_types_pkg::itype_t  i_view;
  rv32i_types_pkg::utype_t  u_view;
  rv32i_types_pkg::ujtype_t j_view;

  logic [pipe_types_pkg::XLEN-1:0] imm_i;
  logic [pipe_types_pkg::XLEN-1:0] imm_u;
  logic [pipe_types_pkg::XLEN-1:0] imm_j;

  pipe_types_pkg::alu_op_t  alu_op;
  logic                     illegal;
  logic                     is_priv;
  pipe_types_pkg::decoded_t dec_d;

  // Format views of the same word
  assign r_view = rv32i_types_pkg::rtype_t'(instr_i);
  assign i_view = rv32i_types_pkg::itype_t'(instr_i);
  assign u_view = rv32i_types_pkg::utype_t'(instr_i);
  assign j_view = rv32i_types_pkg::ujtype_t'(instr_i);
  assign opcode = r_view.opcode;

  assign imm_i = {{20{i_view.imm11_00[11]}}, i_view.imm11_00};
  assign imm_u = {u_view.imm31_12, 12'b0};
  assign imm_j = {{11{j_view.imm20}}, j_view.imm20, j_view.imm19_12,
                  j_view.imm11, j_view.imm10_01, 1'b0};

  // Bit 30 picks SUB over ADD and SRA over SRL
  always_comb begin : alu_op_decode
    alu_op = pipe_types_pkg::ALU_ADD;
    case (opcode)
      rv32i_types_pkg::IMMED: begin
        case (rv32i_types_pkg::funct3_i_t'(i_view.funct3))
          rv32i_types_pkg::ADDI:  alu_op = pipe_types_pkg::ALU_ADD;
          rv32i_types_pkg::SLLI:  alu_op = pipe_types_pkg::ALU_SLL;
          rv32i_types_pkg::SLTI:  alu_op = pipe_types_pkg::ALU_SLT;
          rv32i_types_pkg::SLTIU: alu_op = pipe_types_pkg::ALU_SLTU;
          rv32i_types_pkg::XORI:  alu_op = pipe_types_pkg::ALU_XOR;
          rv32i_types_pkg::SRI:   alu_op = instr_i[30] ? pipe_types_pkg::ALU_SRA
                                                       : pipe_types_pkg::ALU_SRL;
          rv32i_types_pkg::ORI:   alu_op = pipe_types_pkg::ALU_OR;
          rv32i_types_pkg::ANDI:  alu_op = pipe_types_pkg::ALU_AND;
          default:                alu_op = pipe_types_pkg::ALU_ADD;
        endcase
      end
      rv32i_types_pkg::REGREG: begin
        case (rv32i_types_pkg::funct3_r_t'(r_view.funct3))
          rv32i_types_pkg::ADDSUB: alu_op = instr_i[30] ? pipe_types_pkg::ALU_SUB
                                                        : pipe_types_pkg::ALU_ADD;
          rv32i_types_pkg::SLL:    alu_op = pipe_types_pkg::ALU_SLL;
          rv32i_types_pkg::SLT:    alu_op = pipe_types_pkg::ALU_SLT;
          rv32i_types_pkg::SLTU:   alu_op = pipe_types_pkg::ALU_SLTU;
          rv32i_types_pkg::XOR:    alu_op = pipe_types_pkg::ALU_XOR;
          rv32i_types_pkg::SR:     alu_op = instr_i[30] ? pipe_types_pkg::ALU_SRA
                                                        : pipe_types_pkg::ALU_SRL;
          rv32i_types_pkg::OR:     alu_op = pipe_types_pkg::ALU_OR;
          rv32i_types_pkg::AND:    alu_op = pipe_types_pkg::ALU_AND;
          default:                 alu_op = pipe_types_pkg::ALU_ADD;
        endcase
      end
      default: alu_op = pipe_types_pkg::ALU_ADD;
    endcase
  end

  // funct7 bit 0 on REGREG is the M extension, not supported here
  always_comb begin : illegal_decode
    case (opcode)
      rv32i_types_pkg::REGREG: illegal = r_view.funct7[0];
      rv32i_types_pkg::LUI, rv32i_types_pkg::AUIPC, rv32i_types_pkg::JAL,
      rv32i_types_pkg::JALR, rv32i_types_pkg::BRANCH, rv32i_types_pkg::LOAD,
      rv32i_types_pkg::STORE, rv32i_types_pkg::IMMED, rv32i_types_pkg::MISCMEM,
      rv32i_types_pkg::SYSTEM: illegal = 1'b0;
      default:                 illegal = 1'b1;
    endcase
  end

  assign is_priv = (opcode == rv32i_types_pkg::SYSTEM) &&
                   (rv32i_types_pkg::rv32i_system_t'(i_view.funct3) == rv32i_types_pkg::PRIV);

  always_comb begin : word_build
    dec_d         = '0;
    dec_d.valid   = instr_valid_i;
    dec_d.pc      = pc_i;
    dec_d.rs1     = r_view.rs1;
    dec_d.rs2     = r_view.rs2;
    dec_d.rd      = r_view.rd;
    dec_d.alu_op  = alu_op;
    dec_d.illegal = illegal;
    dec_d.ecall   = is_priv && (i_view.imm11_00 == rv32i_types_pkg::ECALL);
    dec_d.ebreak  = is_priv && (i_view.imm11_00 == rv32i_types_pkg::EBREAK);

    case (opcode)
      rv32i_types_pkg::LUI, rv32i_types_pkg::AUIPC: dec_d.imm = imm_u;
      rv32i_types_pkg::JAL:                         dec_d.imm = imm_j;
      default:                                      dec_d.imm = imm_i;
    endcase

    dec_d.a_sel = (opcode == rv32i_types_pkg::AUIPC) ? pipe_types_pkg::A_PC
                                                     : pipe_types_pkg::A_RS1;
    dec_d.b_sel = (opcode == rv32i_types_pkg::REGREG) ? pipe_types_pkg::B_RS2
                                                      : pipe_types_pkg::B_IMM;

    case (opcode)
      rv32i_types_pkg::LUI:                        dec_d.w_sel = pipe_types_pkg::W_IMM;
      rv32i_types_pkg::JAL, rv32i_types_pkg::JALR: dec_d.w_sel = pipe_types_pkg::W_PC4;
      default:                                     dec_d.w_sel = pipe_types_pkg::W_ALU;
    endcase

    // Only the executed classes write a register
    case (opcode)
      rv32i_types_pkg::IMMED, rv32i_types_pkg::REGREG, rv32i_types_pkg::LUI,
      rv32i_types_pkg::AUIPC, rv32i_types_pkg::JAL,
      rv32i_types_pkg::JALR: dec_d.wen = !illegal;
      default:               dec_d.wen = 1'b0;
    endcase
  end

  always_ff @(posedge clk) begin
    dec_o <= dec_d;
    if (rst_i) begin
      dec_o.valid <= 1'b0;
    end
  end

  // System flags only ever come from a SYSTEM opcode
  a_sys_flag_opcode: assert property (
    @(posedge clk) disable iff (rst_i)
    (instr_valid_i && opcode != rv32i_types_pkg::SYSTEM) |=> !(dec_o.ecall || dec_o.ebreak)
  );

endmodule

// ==== verilog/operand_stage.sv ====
module operand_stage (
  input  logic                                  clk,
  input  logic                                  rst_i,
  input  pipe_types_pkg::decoded_t              dec_i,
  input  logic                                  wb_wen_i,
  input  logic [pipe_types_pkg::REG_AW-1:0]     wb_rd_i,
  input  logic [pipe_types_pkg::XLEN-1:0]       wb_data_i,
  output pipe_types_pkg::operands_t             ops_o
);

  logic [pipe_types_pkg::XLEN-1:0] regs [pipe_types_pkg::NUM_REGS];

  logic                            fwd_rs1;
  logic                            fwd_rs2;
  logic [pipe_types_pkg::XLEN-1:0] rs1_val;
  logic [pipe_types_pkg::XLEN-1:0] rs2_val;

  pipe_types_pkg::operands_t ops_d;

  // Register file, written by execute at the same edge it retires
  always_ff @(posedge clk) begin
    if (rst_i) begin
      for (int i = 0; i < pipe_types_pkg::NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wb_wen_i) begin
      regs[wb_rd_i] <= wb_data_i;
    end
  end

  // Bypass from the instruction one ahead
  assign fwd_rs1 = wb_wen_i && (dec_i.rs1 == wb_rd_i) && (dec_i.rs1 != '0);
  assign fwd_rs2 = wb_wen_i && (dec_i.rs2 == wb_rd_i) && (dec_i.rs2 != '0);

  assign rs1_val = fwd_rs1 ? wb_data_i : regs[dec_i.rs1];
  assign rs2_val = fwd_rs2 ? wb_data_i : regs[dec_i.rs2];

  always_comb begin
    ops_d         = '0;
    ops_d.valid   = dec_i.valid;
    ops_d.pc      = dec_i.pc;
    ops_d.imm     = dec_i.imm;
    ops_d.rd      = dec_i.rd;
    ops_d.alu_op  = dec_i.alu_op;
    ops_d.a_sel   = dec_i.a_sel;
    ops_d.b_sel   = dec_i.b_sel;
    ops_d.w_sel   = dec_i.w_sel;
    ops_d.wen     = dec_i.wen;
    ops_d.illegal = dec_i.illegal;
    ops_d.ecall   = dec_i.ecall;
    ops_d.ebreak  = dec_i.ebreak;
    ops_d.rs1_val = rs1_val;
    ops_d.rs2_val = rs2_val;
  end

  always_ff @(posedge clk) begin
    ops_o <= ops_d;
    if (rst_i) begin
      ops_o.valid <= 1'b0;
    end
  end

  // Execute filters x0, so the file never sees such a write
  a_no_x0_write: assert property (
    @(posedge clk) disable iff (rst_i)
    wb_wen_i |-> (wb_rd_i != '0)
  );

endmodule

// ==== verilog/execute_stage.sv ====
module execute_stage (
  input  logic                                  clk,
  input  logic                                  rst_i,
  input  pipe_types_pkg::operands_t             ops_i,
  output logic                                  wb_wen_o,
  output logic [pipe_types_pkg::REG_AW-1:0]     wb_rd_o,
  output logic [pipe_types_pkg::XLEN-1:0]       wb_data_o,
  output logic                                  retire_valid_o,
  output pipe_types_pkg::retire_t               retire_o
);

  logic [pipe_types_pkg::XLEN-1:0] op_a;
  logic [pipe_types_pkg::XLEN-1:0] op_b;
  logic [pipe_types_pkg::XLEN-1:0] alu_res;
  logic [pipe_types_pkg::XLEN-1:0] result;
  logic [4:0]                      shamt;

  assign op_a  = (ops_i.a_sel == pipe_types_pkg::A_PC) ? ops_i.pc : ops_i.rs1_val;
  assign op_b  = (ops_i.b_sel == pipe_types_pkg::B_IMM) ? ops_i.imm : ops_i.rs2_val;
  assign shamt = op_b[4:0];

  always_comb begin : alu
    case (ops_i.alu_op)
      pipe_types_pkg::ALU_ADD:  alu_res = op_a + op_b;
      pipe_types_pkg::ALU_SUB:  alu_res = op_a - op_b;
      pipe_types_pkg::ALU_SLL:  alu_res = op_a << shamt;
      pipe_types_pkg::ALU_SRL:  alu_res = op_a >> shamt;
      pipe_types_pkg::ALU_SRA:  alu_res = $signed(op_a) >>> shamt;
      pipe_types_pkg::ALU_AND:  alu_res = op_a & op_b;
      pipe_types_pkg::ALU_OR:   alu_res = op_a | op_b;
      pipe_types_pkg::ALU_XOR:  alu_res = op_a ^ op_b;
      pipe_types_pkg::ALU_SLT:  alu_res = {31'b0, $signed(op_a) < $signed(op_b)};
      pipe_types_pkg::ALU_SLTU: alu_res = {31'b0, op_a < op_b};
      default:                  alu_res = op_a + op_b;
    endcase
  end

  always_comb begin : wb_select
    case (ops_i.w_sel)
      pipe_types_pkg::W_IMM: result = ops_i.imm;
      pipe_types_pkg::W_PC4: result = ops_i.pc + 32'd4;
      default:               result = alu_res;
    endcase
  end

  // Write port doubles as the forwarding source
  assign wb_wen_o  = ops_i.valid && ops_i.wen && (ops_i.rd != '0);
  assign wb_rd_o   = ops_i.rd;
  // Data reads as zero when nothing is written, so retire records stay clean
  assign wb_data_o = wb_wen_o ? result : '0;

  always_ff @(posedge clk) begin
    if (rst_i) begin
      retire_valid_o <= 1'b0;
    end else begin
      retire_valid_o <= ops_i.valid;
    end
  end

  always_ff @(posedge clk) begin
    retire_o.wen     <= wb_wen_o;
    retire_o.rd      <= wb_rd_o;
    retire_o.data    <= wb_data_o;
    retire_o.illegal <= ops_i.illegal;
    retire_o.ecall   <= ops_i.ecall;
    retire_o.ebreak  <= ops_i.ebreak;
  end

  a_quiet_after_reset: assert property (
    @(posedge clk) rst_i |=> !retire_valid_o
  );

endmodule

// ==== verilog/exec_pipe.sv ====
module exec_pipe (
  input  logic                                  clk,
  input  logic                                  rst_i,
  input  logic                                  instr_valid_i,
  input  logic [31:0]                           instr_i,
  input  logic [pipe_types_pkg::XLEN-1:0]       pc_i,
  output logic                                  retire_valid_o,
  output pipe_types_pkg::retire_t               retire_o
);

  pipe_types_pkg::decoded_t  dec;
  pipe_types_pkg::operands_t ops;

  // Writeback port from execute back into operand read
  logic                              wb_wen;
  logic [pipe_types_pkg::REG_AW-1:0] wb_rd;
  logic [pipe_types_pkg::XLEN-1:0]   wb_data;

  control_unit control_unit_i (
    .clk           (clk),
    .rst_i         (rst_i),
    .instr_valid_i (instr_valid_i),
    .instr_i       (instr_i),
    .pc_i          (pc_i),
    .dec_o         (dec)
  );

  operand_stage operand_stage_i (
    .clk       (clk),
    .rst_i     (rst_i),
    .dec_i     (dec),
    .wb_wen_i  (wb_wen),
    .wb_rd_i   (wb_rd),
    .wb_data_i (wb_data),
    .ops_o     (ops)
  );

  execute_stage execute_stage_i (
    .clk            (clk),
    .rst_i          (rst_i),
    .ops_i          (ops),
    .wb_wen_o       (wb_wen),
    .wb_rd_o        (wb_rd),
    .wb_data_o      (wb_data),
    .retire_valid_o (retire_valid_o),
    .retire_o       (retire_o)
  );

endmodule

// ==== sim/exec_pipe_checker.sv ====
module exec_pipe_checker (
  input  logic                    clk,
  input  logic                    rst_i,
  input  logic                    retire_valid_i,
  input  pipe_types_pkg::retire_t retire_i,
  output int                      checks_o,
  output int                      errors_o
);

  // Cycles from the strobe to the visible retire
  localparam int unsigned LATENCY = 3;

  pipe_types_pkg::retire_t exp_q[$];
  int unsigned             stamp_q[$];
  int unsigned             cycle = 0;
  int                      checks = 0;
  int                      errors = 0;

  assign checks_o = checks;
  assign errors_o = errors;

  always @(posedge clk) begin
    cycle <= cycle + 1;
  end

  task automatic push_expected(input pipe_types_pkg::retire_t exp);
    exp_q.push_back(exp);
    stamp_q.push_back(cycle);
  endtask

  function automatic int outstanding();
    return exp_q.size();
  endfunction

  // Outputs only move at the rising edge, so look at them mid-cycle
  always @(negedge clk) begin : compare
    pipe_types_pkg::retire_t exp;
    int unsigned             stamp;
    if (!rst_i && retire_valid_i) begin
      if (exp_q.size() == 0) begin
        $display("Unexpected retire at time %0t for rd %0d with nothing issued",
                 $time, retire_i.rd);
        errors++;
      end else begin
        exp   = exp_q.pop_front();
        stamp = stamp_q.pop_front();
        checks++;
        if (retire_i !== exp) begin
          $display("FAILED %0t: retire wen %b rd %0d data %h flags %b%b%b", $time,
                   retire_i.wen, retire_i.rd, retire_i.data,
                   retire_i.illegal, retire_i.ecall, retire_i.ebreak);
          $display("  expected wen %b rd %0d data %h flags %b%b%b",
                   exp.wen, exp.rd, exp.data, exp.illegal, exp.ecall, exp.ebreak);
          errors++;
        end
        if (cycle - stamp != LATENCY) begin
          $display("FAILED %0t: retire came %0d cycles after its strobe, expected %0d",
                   $time, cycle - stamp, LATENCY);
          errors++;
        end
      end
    end
  end

endmodule

// ==== sim/exec_pipe_tb.sv ====
module exec_pipe_tb;

  localparam int CLK_PERIOD  = 8;
  localparam int MAX_ENTRIES = 64;
  localparam int DRAIN_LIMIT = 100;

  typedef struct {
    logic [31:0]             instr;
    logic [31:0]             pc;
    int                      gap;
    pipe_types_pkg::retire_t exp;
  } entry_t;

  logic                    clk;
  logic                    rst_i;
  logic                    instr_valid_i;
  logic [31:0]             instr_i;
  logic [31:0]             pc_i;
  logic                    retire_valid_o;
  pipe_types_pkg::retire_t retire_o;
  int                      checks;
  int                      errors;

  entry_t stim [MAX_ENTRIES];
  int     num_entries = 0;

  exec_pipe exec_pipe_i (
    .clk            (clk),
    .rst_i          (rst_i),
    .instr_valid_i  (instr_valid_i),
    .instr_i        (instr_i),
    .pc_i           (pc_i),
    .retire_valid_o (retire_valid_o),
    .retire_o       (retire_o)
  );

  exec_pipe_checker retire_check_i (
    .clk            (clk),
    .rst_i          (rst_i),
    .retire_valid_i (retire_valid_o),
    .retire_i       (retire_o),
    .checks_o       (checks),
    .errors_o       (errors)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  function automatic logic [31:0] itype_word(input rv32i_types_pkg::opcode_t op, input int rd,
                                             input int f3, input int rs1, input int imm);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op};
  endfunction

  function automatic logic [31:0] imm_op(input int rd, input int f3, input int rs1,
                                         input int imm);
    return itype_word(rv32i_types_pkg::IMMED, rd, f3, rs1, imm);
  endfunction

  function automatic logic [31:0] rtype_word(input int f7, input int f3, input int rd,
                                             input int rs1, input int rs2);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], rv32i_types_pkg::REGREG};
  endfunction

  function automatic logic [31:0] utype_word(input rv32i_types_pkg::opcode_t op, input int rd,
                                             input int imm);
    return {imm[19:0], rd[4:0], op};
  endfunction

  function automatic logic [31:0] jtype_word(input int rd, input int imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], rv32i_types_pkg::JAL};
  endfunction

  // Flags are ordered illegal, ecall, ebreak
  task automatic add_entry(input logic [31:0] instr, input logic [31:0] pc, input int gap,
                           input logic wen, input int rd, input logic [31:0] data,
                           input logic [2:0] flags);
    stim[num_entries].instr = instr;
    stim[num_entries].pc    = pc;
    stim[num_entries].gap   = gap;
    stim[num_entries].exp   = {wen, rd[4:0], data, flags};
    num_entries++;
  endtask

  task automatic build_table();
    // Values 0 to 7 of funct3 are add/sub, sll, slt, sltu, xor, sr, or, and
    add_entry(imm_op(1, 0, 0, 5), 32'h100, 4, 1'b1, 1, 32'h0000_0005, 3'b000);
    add_entry(imm_op(2, 0, 0, -3), 32'h104, 4, 1'b1, 2, 32'hFFFF_FFFD, 3'b000);
    add_entry(imm_op(3, 7, 2, 'hF0), 32'h108, 4, 1'b1, 3, 32'h0000_00F0, 3'b000);
    add_entry(imm_op(4, 6, 1, 'h700), 32'h10C, 4, 1'b1, 4, 32'h0000_0705, 3'b000);
    add_entry(imm_op(5, 4, 2, -1), 32'h110, 4, 1'b1, 5, 32'h0000_0002, 3'b000);
    add_entry(imm_op(6, 2, 2, 1), 32'h114, 4, 1'b1, 6, 32'h0000_0001, 3'b000);
    add_entry(imm_op(7, 3, 2, 1), 32'h118, 4, 1'b1, 7, 32'h0000_0000, 3'b000);
    add_entry(imm_op(8, 1, 1, 4), 32'h11C, 4, 1'b1, 8, 32'h0000_0050, 3'b000);
    add_entry(imm_op(9, 5, 2, 28), 32'h120, 4, 1'b1, 9, 32'h0000_000F, 3'b000);
    add_entry(imm_op(10, 5, 2, 'h401), 32'h124, 4, 1'b1, 10, 32'hFFFF_FFFE, 3'b000);
    add_entry(rtype_word('h20, 0, 12, 1, 2), 32'h128, 4, 1'b1, 12, 32'h0000_0008, 3'b000);
    add_entry(rtype_word('h20, 5, 13, 2, 1), 32'h12C, 4, 1'b1, 13, 32'hFFFF_FFFF, 3'b000);
    add_entry(rtype_word(0, 2, 15, 2, 1), 32'h130, 4, 1'b1, 15, 32'h0000_0001, 3'b000);
    add_entry(rtype_word(0, 3, 16, 2, 1), 32'h134, 4, 1'b1, 16, 32'h0000_0000, 3'b000);
    add_entry(rtype_word(0, 1, 17, 1, 1), 32'h138, 4, 1'b1, 17, 32'h0000_00A0, 3'b000);
    add_entry(rtype_word(0, 4, 18, 1, 2), 32'h13C, 4, 1'b1, 18, 32'hFFFF_FFF8, 3'b000);
    add_entry(rtype_word(0, 6, 19, 1, 8), 32'h140, 4, 1'b1, 19, 32'h0000_0055, 3'b000);
    add_entry(rtype_word(0, 7, 20, 2, 4), 32'h144, 4, 1'b1, 20, 32'h0000_0705, 3'b000);
    add_entry(rtype_word(0, 0, 11, 1, 2), 32'h148, 4, 1'b1, 11, 32'h0000_0002, 3'b000);
    add_entry(rtype_word(0, 5, 14, 2, 1), 32'h14C, 4, 1'b1, 14, 32'h07FF_FFFF, 3'b000);
    // Dependency chain with gaps of zero, one and two cycles
    add_entry(imm_op(21, 0, 0, 'h64), 32'h150, 4, 1'b1, 21, 32'h0000_0064, 3'b000);
    add_entry(imm_op(21, 0, 21, 1), 32'h154, 0, 1'b1, 21, 32'h0000_0065, 3'b000);
    add_entry(rtype_word(0, 0, 22, 21, 21), 32'h158, 0, 1'b1, 22, 32'h0000_00CA, 3'b000);
    add_entry(rtype_word('h20, 0, 23, 22, 21), 32'h15C, 1, 1'b1, 23, 32'h0000_0065, 3'b000);
    add_entry(rtype_word(0, 4, 24, 23, 22), 32'h160, 2, 1'b1, 24, 32'h0000_00AF, 3'b000);
    add_entry(rtype_word(0, 0, 25, 24, 23), 32'h164, 0, 1'b1, 25, 32'h0000_0114, 3'b000);
    add_entry(rtype_word(0, 0, 26, 24, 25), 32'h168, 0, 1'b1, 26, 32'h0000_01C3, 3'b000);
    add_entry(utype_word(rv32i_types_pkg::LUI, 27, 'h12345), 32'h200, 4, 1'b1, 27,
              32'h1234_5000, 3'b000);
    add_entry(utype_word(rv32i_types_pkg::AUIPC, 28, 1), 32'h204, 0, 1'b1, 28,
              32'h0000_1204, 3'b000);
    add_entry(jtype_word(1, 8), 32'h208, 0, 1'b1, 1, 32'h0000_020C, 3'b000);
    add_entry(itype_word(rv32i_types_pkg::JALR, 29, 0, 27, 0), 32'h20C, 0, 1'b1, 29,
              32'h0000_0210, 3'b000);
    // x0 takes no write and still reads zero right after
    add_entry(imm_op(0, 0, 1, 7), 32'h210, 0, 1'b0, 0, 32'h0, 3'b000);
    add_entry(imm_op(30, 0, 0, 'h7FF), 32'h214, 0, 1'b1, 30, 32'h0000_07FF, 3'b000);
    add_entry(32'hFFFF_FFFF, 32'h300, 4, 1'b0, 31, 32'h0, 3'b100);
    add_entry(rtype_word(1, 0, 3, 1, 2), 32'h304, 0, 1'b0, 3, 32'h0, 3'b100);
    add_entry(itype_word(rv32i_types_pkg::SYSTEM, 0, 0, 0, 0), 32'h308, 0, 1'b0, 0, 32'h0, 3'b010);
    add_entry(itype_word(rv32i_types_pkg::SYSTEM, 0, 0, 0, 1), 32'h30C, 1, 1'b0, 0, 32'h0, 3'b001);
    add_entry(itype_word(rv32i_types_pkg::BRANCH, 8, 0, 1, 2), 32'h310, 0, 1'b0, 8, 32'h0, 3'b000);
    add_entry(itype_word(rv32i_types_pkg::STORE, 4, 2, 1, 2), 32'h314, 0, 1'b0, 4, 32'h0, 3'b000);
    add_entry(itype_word(rv32i_types_pkg::LOAD, 5, 2, 1, 'h10), 32'h318, 0, 1'b0, 5, 32'h0, 3'b000);
    add_entry(itype_word(rv32i_types_pkg::SYSTEM, 6, 1, 1, 'h300), 32'h31C, 2, 1'b0, 6, 32'h0,
              3'b000);
    // Load above must have left x5 alone
    add_entry(imm_op(31, 0, 5, 0), 32'h320, 0, 1'b1, 31, 32'h0000_0002, 3'b000);
  endtask

  task automatic run_table(input logic random_gaps);
    int extra;
    for (int i = 0; i < num_entries; i++) begin
      extra = random_gaps ? $urandom_range(2, 0) : 0;
      repeat (stim[i].gap + extra) @(negedge clk);
      instr_valid_i = 1'b1;
      instr_i       = stim[i].instr;
      pc_i          = stim[i].pc;
      retire_check_i.push_expected(stim[i].exp);
      @(negedge clk);
      instr_valid_i = 1'b0;
      instr_i       = '0;
    end
  endtask

  initial begin : stimulus
    int unsigned seed_val;
    int          drain_cycles;
    int          left;
    seed_val      = $urandom(32'hc7f8);
    rst_i         = 1'b1;
    instr_valid_i = 1'b0;
    instr_i       = '0;
    pc_i          = '0;
    build_table();
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_i = 1'b0;

    // Table gaps first, then the same table with random extra idle cycles
    run_table(1'b0);
    run_table(1'b1);

    drain_cycles = 0;
    while (retire_check_i.outstanding() != 0 && drain_cycles < DRAIN_LIMIT) begin
      @(posedge clk);
      drain_cycles++;
    end
    left = retire_check_i.outstanding();
    if (left != 0) begin
      $display("Timed out waiting for %0d instructions to retire", left);
    end
    $display("Retires checked: %0d, errors: %0d, never retired: %0d", checks, errors, left);
    if (errors == 0 && left == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// ==== filelist.f ====
verilog/rv32i_types_pkg.sv
verilog/pipe_types_pkg.sv
verilog/control_unit.sv
verilog/operand_stage.sv
verilog/execute_stage.sv
verilog/exec_pipe.sv
sim/exec_pipe_checker.sv
sim/exec_pipe_tb.sv

// ==== Makefile ====
SIM      ?= verilator
FLAGS    ?= --binary --timing --assert -j 0
TOP      := exec_pipe_tb
FILELIST := filelist.f
BUILD    := obj_dir
LOG      := sim.log
PASS_MSG := Finished with no errors

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "Simulation failed"; exit 1)
	@echo "Simulation passed"

clean:
	rm -rf $(BUILD) $(LOG)
